// File: common/bmc_pkg.sv
package bmc_pkg;

  // bus word and address widths of the register bus
  typedef logic [15:0] wb_addr_t;
  typedef logic [15:0] wb_data_t;

  localparam int NUM_SLAVES       = 3;
  localparam int SLAVE_SYS_CONFIG = 0;
  localparam int SLAVE_IRQ        = 1;
  localparam int SLAVE_BUS_MON    = 2;

  // address map, each slave owns a window of 16 words
  localparam wb_addr_t MEM_SYSCONF_A = 16'h0000;
  localparam wb_addr_t MEM_SYSCONF_H = 16'h000F;
  localparam wb_addr_t MEM_IRQC_A    = 16'h0010;
  localparam wb_addr_t MEM_IRQC_H    = 16'h001F;
  localparam wb_addr_t MEM_BUSMON_A  = 16'h0020;
  localparam wb_addr_t MEM_BUSMON_H  = 16'h002F;

  localparam int REG_OFFSET_BITS = 4;

  // register offsets inside each window
  localparam logic [REG_OFFSET_BITS-1:0] SYSCONF_REG_ID     = 4'd0;
  localparam logic [REG_OFFSET_BITS-1:0] SYSCONF_REG_REV    = 4'd1;
  localparam logic [REG_OFFSET_BITS-1:0] SYSCONF_REG_CONFIG = 4'd2;
  localparam logic [REG_OFFSET_BITS-1:0] IRQC_REG_STATUS    = 4'd0;
  localparam logic [REG_OFFSET_BITS-1:0] IRQC_REG_MASK      = 4'd1;
  localparam logic [REG_OFFSET_BITS-1:0] BUSMON_REG_ADDR    = 4'd0;
  localparam logic [REG_OFFSET_BITS-1:0] BUSMON_REG_WE      = 4'd1;
  localparam logic [REG_OFFSET_BITS-1:0] BUSMON_REG_COUNT   = 4'd2;

  // board identity and revision
  localparam wb_data_t    BOARD_ID  = 16'h0B4C;
  localparam logic [7:0]  REV_MAJOR = 8'h01;
  localparam logic [7:0]  REV_MINOR = 8'h03;

  typedef logic [7:0] sys_config_t;
  localparam sys_config_t DEFAULT_SYS_CONFIG = 8'h05;

  localparam int NUM_IRQ_SOURCES = 4;
  typedef logic [NUM_IRQ_SOURCES-1:0] irq_vec_t;
  // sources 0 to 2 come from outside the register bus
  localparam int IRQ_SRC_MEMV = 3;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    wb_data_t dat;
    logic     ack;
    logic     err;
  } wb_rsp_t;

  // one pulse per access that hit no slave window
  typedef struct packed {
    logic     memv;
    logic     we;
    wb_addr_t addr;
  } bm_event_t;

endpackage

// File: wb_bus/wbs_arbiter.sv
`timescale 1ns/1ps

module wbs_arbiter
  import bmc_pkg::*;
(
  input  logic                  wb_clk_i,
  input  logic                  rst_i,
  input  wb_req_t               wbm_req_i,
  output wb_rsp_t               wbm_rsp_o,
  output wb_req_t               wbs_req_o,
  output logic [NUM_SLAVES-1:0] wbs_sel_o,
  input  wb_rsp_t               wbs_rsp_i [NUM_SLAVES],
  output bm_event_t             bm_event_o
);

  function automatic logic in_window(wb_addr_t adr, wb_addr_t base, wb_addr_t high);
    return (adr >= base) && (adr <= high);
  endfunction

  logic [NUM_SLAVES-1:0] hit;
  logic                  access;
  logic                  unmapped;
  logic                  err_start;
  logic                  err_q;
  logic                  memv_q;
  logic                  ev_we_q;
  wb_addr_t              ev_addr_q;

  assign hit[SLAVE_SYS_CONFIG] = in_window(wbm_req_i.adr, MEM_SYSCONF_A, MEM_SYSCONF_H);
  assign hit[SLAVE_IRQ]        = in_window(wbm_req_i.adr, MEM_IRQC_A, MEM_IRQC_H);
  assign hit[SLAVE_BUS_MON]    = in_window(wbm_req_i.adr, MEM_BUSMON_A, MEM_BUSMON_H);

  assign access    = wbm_req_i.cyc & wbm_req_i.stb;
  assign unmapped  = access & ~(|hit);
  // err is a single pulse even though the master still holds stb during it
  assign err_start = unmapped & ~err_q;

  assign wbs_sel_o = hit & {NUM_SLAVES{access}};

  // slaves never see a strobe for an address nobody owns
  always_comb begin
    wbs_req_o     = wbm_req_i;
    wbs_req_o.stb = wbm_req_i.stb & ~unmapped;
  end

  // windows are disjoint, so at most one slave response is picked
  always_comb begin
    wbm_rsp_o = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (hit[i]) begin
        wbm_rsp_o = wbs_rsp_i[i];
      end
    end
    wbm_rsp_o.err = wbm_rsp_o.err | err_q;
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      err_q  <= 1'b0;
      memv_q <= 1'b0;
    end else begin
      err_q  <= err_start;
      memv_q <= err_start;
    end
  end

  // the violating address is only meaningful while memv is high
  always_ff @(posedge wb_clk_i) begin
    if (err_start) begin
      ev_addr_q <= wbm_req_i.adr;
      ev_we_q   <= wbm_req_i.we;
    end
  end

  assign bm_event_o = '{memv: memv_q, we: ev_we_q, addr: ev_addr_q};

endmodule

// File: verilog/sys_config.sv
`timescale 1ns/1ps

module sys_config
  import bmc_pkg::*;
(
  input  logic        wb_clk_i,
  input  logic        rst_i,
  input  wb_req_t     wbs_req_i,
  input  logic        wbs_sel_i,
  output wb_rsp_t     wbs_rsp_o,
  output sys_config_t sys_config_o
);

  logic                       strobe;
  logic                       take;
  logic                       ack_q;
  logic [REG_OFFSET_BITS-1:0] reg_off;
  wb_data_t                   rdata_q;
  sys_config_t                config_q;

  assign strobe  = wbs_sel_i & wbs_req_i.cyc & wbs_req_i.stb;
  // accept only on the first strobe cycle so ack stays one cycle wide
  assign take    = strobe & ~ack_q;
  assign reg_off = wbs_req_i.adr[REG_OFFSET_BITS-1:0];

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      config_q <= DEFAULT_SYS_CONFIG;
    end else begin
      ack_q <= take;
      // identity and revision are read only, writes there are dropped
      if (take && wbs_req_i.we && reg_off == SYSCONF_REG_CONFIG) begin
        config_q <= wbs_req_i.dat[7:0];
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (take) begin
      case (reg_off)
        SYSCONF_REG_ID:     rdata_q <= BOARD_ID;
        SYSCONF_REG_REV:    rdata_q <= {REV_MAJOR, REV_MINOR};
        SYSCONF_REG_CONFIG: rdata_q <= wb_data_t'(config_q);
        default:            rdata_q <= '0;
      endcase
    end
  end

  assign wbs_rsp_o    = '{dat: rdata_q, ack: ack_q, err: 1'b0};
  assign sys_config_o = config_q;

endmodule

// File: verilog/irq_controller.sv
`timescale 1ns/1ps

module irq_controller
  import bmc_pkg::*;
(
  input  logic     wb_clk_i,
  input  logic     rst_i,
  input  wb_req_t  wbs_req_i,
  input  logic     wbs_sel_i,
  output wb_rsp_t  wbs_rsp_o,
  input  irq_vec_t irq_src_i,
  output logic     irq_o
);

  logic                       strobe;
  logic                       take;
  logic                       ack_q;
  logic [REG_OFFSET_BITS-1:0] reg_off;
  wb_data_t                   rdata_q;
  irq_vec_t                   status_q;
  irq_vec_t                   mask_q;
  irq_vec_t                   clear;

  assign strobe  = wbs_sel_i & wbs_req_i.cyc & wbs_req_i.stb;
  assign take    = strobe & ~ack_q;
  assign reg_off = wbs_req_i.adr[REG_OFFSET_BITS-1:0];

  // write one to clear on the status register
  always_comb begin
    clear = '0;
    if (take && wbs_req_i.we && reg_off == IRQC_REG_STATUS) begin
      clear = wbs_req_i.dat[NUM_IRQ_SOURCES-1:0];
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      status_q <= '0;
      mask_q   <= '0;
    end else begin
      ack_q <= take;
      // a source still high wins over a clear in the same cycle
      status_q <= (status_q & ~clear) | irq_src_i;
      if (take && wbs_req_i.we && reg_off == IRQC_REG_MASK) begin
        mask_q <= wbs_req_i.dat[NUM_IRQ_SOURCES-1:0];
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (take) begin
      case (reg_off)
        IRQC_REG_STATUS: rdata_q <= wb_data_t'(status_q);
        IRQC_REG_MASK:   rdata_q <= wb_data_t'(mask_q);
        default:         rdata_q <= '0;
      endcase
    end
  end

  assign wbs_rsp_o = '{dat: rdata_q, ack: ack_q, err: 1'b0};

  // status is recorded whatever the mask, only the line is masked
  assign irq_o = |(status_q & mask_q);

endmodule

// File: verilog/bus_monitor.sv
`timescale 1ns/1ps

module bus_monitor
  import bmc_pkg::*;
(
  input  logic      wb_clk_i,
  input  logic      rst_i,
  input  wb_req_t   wbs_req_i,
  input  logic      wbs_sel_i,
  output wb_rsp_t   wbs_rsp_o,
  input  bm_event_t bm_event_i
);

  logic                       strobe;
  logic                       take;
  logic                       ack_q;
  logic [REG_OFFSET_BITS-1:0] reg_off;
  wb_data_t                   rdata_q;
  wb_addr_t                   viol_addr_q;
  logic                       viol_we_q;
  wb_data_t                   viol_count_q;

  assign strobe  = wbs_sel_i & wbs_req_i.cyc & wbs_req_i.stb;
  assign take    = strobe & ~ack_q;
  assign reg_off = wbs_req_i.adr[REG_OFFSET_BITS-1:0];

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_q        <= 1'b0;
      viol_addr_q  <= '0;
      viol_we_q    <= 1'b0;
      viol_count_q <= '0;
    end else begin
      ack_q <= take;
      if (bm_event_i.memv) begin
        viol_addr_q <= bm_event_i.addr;
        viol_we_q   <= bm_event_i.we;
      end
      // any write to the count register clears it, the data is ignored
      if (take && wbs_req_i.we && reg_off == BUSMON_REG_COUNT) begin
        viol_count_q <= '0;
      end else if (bm_event_i.memv && viol_count_q != '1) begin
        viol_count_q <= viol_count_q + 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (take) begin
      case (reg_off)
        BUSMON_REG_ADDR:  rdata_q <= viol_addr_q;
        BUSMON_REG_WE:    rdata_q <= wb_data_t'(viol_we_q);
        BUSMON_REG_COUNT: rdata_q <= viol_count_q;
        default:          rdata_q <= '0;
      endcase
    end
  end

  assign wbs_rsp_o = '{dat: rdata_q, ack: ack_q, err: 1'b0};

endmodule

// File: verilog/bmc_top.sv
`timescale 1ns/1ps

module bmc_top
  import bmc_pkg::*;
(
  input  logic        wb_clk_i,
  input  logic        rst_i,
  input  wb_req_t     wbm_req_i,
  output wb_rsp_t     wbm_rsp_o,
  input  logic [2:0]  ext_irq_i,
  output logic        irq_o,
  output sys_config_t sys_config_o
);

  wb_req_t               wbs_req;
  logic [NUM_SLAVES-1:0] wbs_sel;
  wb_rsp_t               wbs_rsp [NUM_SLAVES];
  bm_event_t             bm_event;
  irq_vec_t              irq_src;

  // external lines on the low sources, bus violations on their own bit
  always_comb begin
    irq_src               = '0;
    irq_src[2:0]          = ext_irq_i;
    irq_src[IRQ_SRC_MEMV] = bm_event.memv;
  end

  wbs_arbiter wbs_arbiter_inst (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i),
    .wbm_req_i(wbm_req_i), .wbm_rsp_o(wbm_rsp_o),
    .wbs_req_o(wbs_req), .wbs_sel_o(wbs_sel), .wbs_rsp_i(wbs_rsp),
    .bm_event_o(bm_event)
  );

  sys_config sys_config_inst (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i),
    .wbs_req_i(wbs_req), .wbs_sel_i(wbs_sel[SLAVE_SYS_CONFIG]),
    .wbs_rsp_o(wbs_rsp[SLAVE_SYS_CONFIG]),
    .sys_config_o(sys_config_o)
  );

  irq_controller irq_controller_inst (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i),
    .wbs_req_i(wbs_req), .wbs_sel_i(wbs_sel[SLAVE_IRQ]),
    .wbs_rsp_o(wbs_rsp[SLAVE_IRQ]),
    .irq_src_i(irq_src), .irq_o(irq_o)
  );

  bus_monitor bus_monitor_inst (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i),
    .wbs_req_i(wbs_req), .wbs_sel_i(wbs_sel[SLAVE_BUS_MON]),
    .wbs_rsp_o(wbs_rsp[SLAVE_BUS_MON]),
    .bm_event_i(bm_event)
  );

endmodule

// File: bench/tb_bmc_top.sv
`timescale 1ns/1ps

module tb_bmc_top
  import bmc_pkg::*;
();

  localparam int RESET_CYCLES     = 10;
  localparam int CYCLES_PER_LINE  = 20;
  localparam int RESP_WAIT_CYCLES = 4;

  // one operation of the tests file, fields as read from the file
  typedef struct packed {
    logic [7:0]  op;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
  } test_line_t;

  logic        wb_clk;
  logic        rst;
  wb_req_t     wbm_req;
  wb_rsp_t     wbm_rsp;
  logic [2:0]  ext_irq;
  logic        irq;
  sys_config_t sys_config;

  test_line_t tests [$];
  int         mismatches;
  int         no_responses;
  int         file_errors;
  int         cycle_cnt;
  int         cycle_limit;

  bmc_top i_bmc_top (
    .wb_clk_i(wb_clk), .rst_i(rst),
    .wbm_req_i(wbm_req), .wbm_rsp_o(wbm_rsp),
    .ext_irq_i(ext_irq), .irq_o(irq),
    .sys_config_o(sys_config)
  );

  initial wb_clk = 1'b0;
  always #50 wb_clk = ~wb_clk;

  // the limit stays zero until the tests file has been read
  always @(posedge wb_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("run stopped after %0d cycles without reaching the end of %0d test lines",
               cycle_cnt, tests.size());
      $display("errors: %0d mismatches, %0d missing responses, %0d tests file problems",
               mismatches, no_responses, file_errors);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic load_tests();
    int          fd;
    int          code;
    logic [7:0]  op_word;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    logic [8*200-1:0] rest;
    test_line_t  entry;
    fd = $fopen("bench/bmc_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the tests file bench/bmc_tests.txt");
      file_errors++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", op_word);
      if (code != 1) break;
      if (op_word == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h", a, b, c);
        if (code != 3) begin
          $display("tests file line for operation %s does not hold three fields", op_word);
          file_errors++;
          break;
        end
        entry = '{op: op_word, a: a, b: b, c: c};
        tests.push_back(entry);
      end
    end
    $fclose(fd);
  endtask

  // one classic Wishbone cycle, response sampled at the falling edge
  task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                            output wb_data_t rdata, output logic ack, output logic err,
                            output logic got);
    int waited;
    @(posedge wb_clk);
    #1;
    wbm_req.cyc = 1'b1;
    wbm_req.stb = 1'b1;
    wbm_req.we  = we;
    wbm_req.adr = adr;
    wbm_req.dat = wdata;
    got    = 1'b0;
    ack    = 1'b0;
    err    = 1'b0;
    rdata  = '0;
    waited = 0;
    while (!got && waited < RESP_WAIT_CYCLES) begin
      @(negedge wb_clk);
      waited++;
      if (wbm_rsp.ack || wbm_rsp.err) begin
        got   = 1'b1;
        ack   = wbm_rsp.ack;
        err   = wbm_rsp.err;
        rdata = wbm_rsp.dat;
      end
    end
    @(posedge wb_clk);
    #1;
    wbm_req = '0;
  endtask

  task automatic check_access(input test_line_t t);
    logic     we;
    logic     exp_err;
    wb_data_t rdata;
    logic     ack;
    logic     err;
    logic     got;
    we      = (t.op == "W");
    exp_err = t.c[0];
    bus_access(we, t.a, t.b, rdata, ack, err, got);
    assert (got) else begin
      $display("no bus response to %s at address %h within %0d cycles",
               t.op, t.a, RESP_WAIT_CYCLES);
      no_responses++;
    end
    if (got) begin
      assert (ack == !exp_err && err == exp_err) else begin
        $display("Mismatch at %0t: %s %h gave ack %b err %b, expected err %b",
                 $time, t.op, t.a, ack, err, exp_err);
        mismatches++;
      end
      if (!we && !exp_err) begin
        assert (rdata == t.b) else begin
          $display("Mismatch at %0t: read %h returned %h, expected %h",
                   $time, t.a, rdata, t.b);
          mismatches++;
        end
      end
    end
  endtask

  task automatic pulse_irq(input logic [2:0] value);
    @(posedge wb_clk);
    #1;
    ext_irq = value;
    @(posedge wb_clk);
    #1;
    ext_irq = '0;
  endtask

  task automatic check_irq(input logic level);
    repeat (2) @(posedge wb_clk);
    @(negedge wb_clk);
    assert (irq == level) else begin
      $display("Mismatch at %0t: irq_o is %b, expected %b", $time, irq, level);
      mismatches++;
    end
  endtask

  task automatic check_config(input sys_config_t value);
    @(negedge wb_clk);
    assert (sys_config == value) else begin
      $display("Mismatch at %0t: sys_config_o is %h, expected %h", $time, sys_config, value);
      mismatches++;
    end
  endtask

  task automatic run_tests();
    foreach (tests[i]) begin
      case (tests[i].op)
        "W", "R": check_access(tests[i]);
        "I":      pulse_irq(tests[i].a[2:0]);
        "Q":      check_irq(tests[i].a[0]);
        "C":      check_config(tests[i].a[7:0]);
        default: begin
          $display("unknown operation %s in the tests file", tests[i].op);
          file_errors++;
        end
      endcase
    end
  endtask

  initial begin
    rst          = 1'b1;
    wbm_req      = '0;
    ext_irq      = '0;
    mismatches   = 0;
    no_responses = 0;
    file_errors  = 0;
    cycle_cnt    = 0;
    cycle_limit  = 0;
    load_tests();
    cycle_limit = RESET_CYCLES + CYCLES_PER_LINE * tests.size();
    repeat (RESET_CYCLES) @(posedge wb_clk);
    #1;
    rst = 1'b0;
    run_tests();
    repeat (2) @(posedge wb_clk);
    $display("errors: %0d mismatches, %0d missing responses, %0d tests file problems",
             mismatches, no_responses, file_errors);
    if (mismatches + no_responses + file_errors == 0 && tests.size() > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: bench/bmc_tests.txt
# op  addr_or_value  data_or_expected  expect_err
# ops W write  R read  I ext irq pulse  Q irq_o level  C sys_config_o value
R 0000 0B4C 0
R 0001 0103 0
C 0005 0000 0
W 0002 00A5 0
C 00A5 0000 0
R 0002 00A5 0
W 0000 FFFF 0
W 0001 1234 0
R 0000 0B4C 0
R 0001 0103 0
W 0040 1111 1
R 0100 0000 1
R 0020 0100 0
R 0021 0000 0
R 0022 0002 0
W 0022 0000 0
R 0022 0000 0
I 0001 0000 0
Q 0000 0000 0
R 0010 0009 0
W 0011 0001 0
Q 0001 0000 0
W 0010 0009 0
Q 0000 0000 0
R 0010 0000 0
W 0011 0008 0
Q 0000 0000 0
W 0050 ABCD 1
Q 0001 0000 0
R 0020 0050 0
R 0021 0001 0
R 0022 0001 0

// File: sources.f
common/bmc_pkg.sv
wb_bus/wbs_arbiter.sv
verilog/sys_config.sv
verilog/irq_controller.sv
verilog/bus_monitor.sv
verilog/bmc_top.sv
bench/tb_bmc_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sources.f --top-module tb_bmc_top -Mdir obj_dir -o tb_bmc_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_bmc_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
